// File: source/queue_states_cfg.svh
/* Sizing of the queue-state store, shared by the RTL and the testbench.
   Include in any file that sizes an array or a type from these values. */
`ifndef QUEUE_STATES_CFG_SVH
`define QUEUE_STATES_CFG_SVH

//////////////////////////////////////////////////
// Buffer geometry
//////////////////////////////////////////////////

// Egress queues served by the store
`define QS_NUM_QUEUES 4

// Page ids and also the page-list slots per queue
`define QS_NUM_PAGES 8

// Words in one page as a power of two
`define QS_WORDS_PER_PAGE 4

// Bytes carried by one buffer word
`define QS_BYTES_PER_WORD 8

`endif

// File: source/queue_states_pkg.sv
/* Width types of the queue-state store, used by the RTL and the testbench.
   Import with a wildcard in the module header. */
`include "queue_states_cfg.svh"

package queue_states_pkg;

    //////////////////////////////////////////////////
    // Identifiers
    //////////////////////////////////////////////////

    // Egress queue index
    typedef logic [$clog2(`QS_NUM_QUEUES)-1:0] queue_id_t;

    // Page id handed out by the allocator
    typedef logic [$clog2(`QS_NUM_PAGES)-1:0] page_id_t;

    // Word offset inside a page
    typedef logic [$clog2(`QS_WORDS_PER_PAGE)-1:0] word_idx_t;

    //////////////////////////////////////////////////
    // Page list and occupancy
    //////////////////////////////////////////////////

    // Position in one queue's page list
    typedef logic [$clog2(`QS_NUM_PAGES)-1:0] slot_idx_t;

    // Page RAM address with the queue id above the slot
    typedef logic [$bits(queue_id_t)+$bits(slot_idx_t)-1:0] ram_addr_t;

    // Byte count with one extra bit so a full buffer still fits
    typedef logic [$clog2(`QS_NUM_PAGES*`QS_WORDS_PER_PAGE*`QS_BYTES_PER_WORD):0] byte_count_t;

endpackage

// File: source/queue_occupancy.sv
/* Per-queue byte occupancy counters, raised by enqueue and lowered by dequeue.
   A read request returns the count one cycle later. */
`timescale 1ns/1ps
`include "queue_states_cfg.svh"

module queue_occupancy
    import queue_states_pkg::*;
(
    input  logic        enqueue_queue_occupancy_a4l,
    input  logic        rst_n,
    input  logic        enq_valid,
    input  queue_id_t   enq_queue,
    input  byte_count_t enq_bytes,
    input  logic        deq_valid,
    input  queue_id_t   deq_queue,
    input  byte_count_t deq_bytes,
    input  logic        occ_rd_valid,
    input  queue_id_t   occ_rd_queue,
    output logic        occ_rd_done,
    output byte_count_t occ_rd_bytes
);

    byte_count_t occupancy [`QS_NUM_QUEUES];
    logic        same_queue;

    // Both strobes on one queue fold into a single write
    assign same_queue = enq_valid && deq_valid && (enq_queue == deq_queue);

    //////////////////////////////////////////////////
    // Counter update
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            occupancy <= '{default: '0};
        end else if (same_queue) begin
            occupancy[enq_queue] <= occupancy[enq_queue] + enq_bytes - deq_bytes;
        end else begin
            if (enq_valid) begin
                occupancy[enq_queue] <= occupancy[enq_queue] + enq_bytes;
            end
            if (deq_valid) begin
                occupancy[deq_queue] <= occupancy[deq_queue] - deq_bytes;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read-back
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            occ_rd_done <= 1'b0;
        end else begin
            occ_rd_done <= occ_rd_valid;
        end
    end

    // Sampled before this cycle's update lands
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (occ_rd_valid) begin
            occ_rd_bytes <= occupancy[occ_rd_queue];
        end
    end

endmodule

// File: source/page_ptr_ram.sv
/* Page-pointer storage for every queue's page list.
   One write port and two read ports, all synchronous. */
`timescale 1ns/1ps
`include "queue_states_cfg.svh"

module page_ptr_ram (
    input  logic                                          enqueue_queue_occupancy_a4l,
    input  logic                                          ram_we,
    input  logic [$clog2(`QS_NUM_QUEUES*`QS_NUM_PAGES)-1:0] ram_waddr,
    input  logic [$clog2(`QS_NUM_PAGES)-1:0]               ram_wdata,
    input  logic [$clog2(`QS_NUM_QUEUES*`QS_NUM_PAGES)-1:0] ram_raddr_a,
    input  logic [$clog2(`QS_NUM_QUEUES*`QS_NUM_PAGES)-1:0] ram_raddr_b,
    output logic [$clog2(`QS_NUM_PAGES)-1:0]               ram_rdata_a,
    output logic [$clog2(`QS_NUM_PAGES)-1:0]               ram_rdata_b
);

    // One slot per page per queue
    localparam int DEPTH  = `QS_NUM_QUEUES * `QS_NUM_PAGES;
    localparam int DATA_W = $clog2(`QS_NUM_PAGES);

    logic [DATA_W-1:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (ram_we) begin
            mem[ram_waddr] <= ram_wdata;
        end
    end

    // Port a serves tail reads, port b head pops
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        ram_rdata_a <= mem[ram_raddr_a];
        ram_rdata_b <= mem[ram_raddr_b];
    end

endmodule

// File: source/queue_page_list.sv
/* Tail and head pointers, page-list slots and empty flags for each queue.
   Drives the page-pointer RAM for appends, tail lookups and head pops. */
`timescale 1ns/1ps
`include "queue_states_cfg.svh"

module queue_page_list
    import queue_states_pkg::*;
(
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      rst_n,
    input  logic                      tail_wr_valid,
    input  queue_id_t                 tail_wr_queue,
    input  word_idx_t                 tail_wr_ptr,
    input  logic                      tail_wr_new_page,
    input  page_id_t                  tail_wr_page,
    input  logic                      tail_rd_valid,
    input  queue_id_t                 tail_rd_queue,
    input  logic                      head_pop_valid,
    input  queue_id_t                 head_pop_queue,
    input  page_id_t                  ram_rdata_a,
    input  page_id_t                  ram_rdata_b,
    output logic                      tail_rd_done,
    output word_idx_t                 tail_rd_ptr,
    output page_id_t                  tail_rd_page,
    output logic                      tail_rd_page_valid,
    output logic                      head_pop_done,
    output word_idx_t                 head_pop_ptr,
    output page_id_t                  head_pop_page,
    output logic [`QS_NUM_QUEUES-1:0] queue_empty,
    output logic                      ram_we,
    output ram_addr_t                 ram_waddr,
    output page_id_t                  ram_wdata,
    output ram_addr_t                 ram_raddr_a,
    output ram_addr_t                 ram_raddr_b
);

    word_idx_t tail_ptr [`QS_NUM_QUEUES];
    word_idx_t head_ptr [`QS_NUM_QUEUES];
    slot_idx_t wr_slot  [`QS_NUM_QUEUES];
    slot_idx_t rd_slot  [`QS_NUM_QUEUES];

    // Set once a queue's list has held a page
    logic [`QS_NUM_QUEUES-1:0] has_page;

    slot_idx_t append_slot;
    word_idx_t head_next;
    slot_idx_t rd_slot_next;

    //////////////////////////////////////////////////
    // Next-state terms
    //////////////////////////////////////////////////

    // First page lands in slot 0, later ones one past the write slot
    assign append_slot = has_page[tail_wr_queue] ? wr_slot[tail_wr_queue] + 1'b1 : '0;

    // Word offset wraps on its own since the page size is a power of two
    assign head_next    = head_ptr[head_pop_queue] + 1'b1;
    assign rd_slot_next = (head_next == '0) ? rd_slot[head_pop_queue] + 1'b1
                                            : rd_slot[head_pop_queue];

    // Lookups in the request cycle so RAM data meets the done pulse
    assign ram_raddr_a = {tail_rd_queue, wr_slot[tail_rd_queue]};
    assign ram_raddr_b = {head_pop_queue, rd_slot[head_pop_queue]};

    assign tail_rd_page  = ram_rdata_a;
    assign head_pop_page = ram_rdata_b;

    //////////////////////////////////////////////////
    // Tail side
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            tail_ptr <= '{default: '0};
            wr_slot  <= '{default: '0};
            has_page <= '0;
            ram_we   <= 1'b0;
        end else begin
            ram_we <= 1'b0;
            if (tail_wr_valid) begin
                tail_ptr[tail_wr_queue] <= tail_wr_ptr;
                if (tail_wr_new_page) begin
                    ram_we                  <= 1'b1;
                    has_page[tail_wr_queue] <= 1'b1;
                    wr_slot[tail_wr_queue]  <= append_slot;
                end
            end
        end
    end

    // Append reaches the RAM one cycle after the tail write
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail_wr_valid && tail_wr_new_page) begin
            ram_waddr <= {tail_wr_queue, append_slot};
            ram_wdata <= tail_wr_page;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            tail_rd_done <= 1'b0;
        end else begin
            tail_rd_done <= tail_rd_valid;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail_rd_valid) begin
            tail_rd_ptr        <= tail_ptr[tail_rd_queue];
            tail_rd_page_valid <= has_page[tail_rd_queue];
        end
    end

    //////////////////////////////////////////////////
    // Head side
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            head_ptr      <= '{default: '0};
            rd_slot       <= '{default: '0};
            head_pop_done <= 1'b0;
        end else begin
            head_pop_done <= head_pop_valid;
            if (head_pop_valid) begin
                head_ptr[head_pop_queue] <= head_next;
                rd_slot[head_pop_queue]  <= rd_slot_next;
            end
        end
    end

    // Offset returned is the one before the advance
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (head_pop_valid) begin
            head_pop_ptr <= head_ptr[head_pop_queue];
        end
    end

    //////////////////////////////////////////////////
    // Empty flags
    //////////////////////////////////////////////////

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (!rst_n) begin
            queue_empty <= '1;
        end else begin
            if (head_pop_valid && head_next == tail_ptr[head_pop_queue] &&
                rd_slot_next == wr_slot[head_pop_queue]) begin
                queue_empty[head_pop_queue] <= 1'b1;
            end
            // A tail write on the same queue overrides the set above
            if (tail_wr_valid) begin
                queue_empty[tail_wr_queue] <= 1'b0;
            end
        end
    end

endmodule

// File: source/queue_states.sv
/* Top of the queue-state store for the router's shared buffer.
   Joins the occupancy counters, the page lists and the page-pointer RAM. */
`timescale 1ns/1ps
`include "queue_states_cfg.svh"

module queue_states
    import queue_states_pkg::*;
(
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      rst_n,
    // Occupancy
    input  logic                      enq_valid,
    input  queue_id_t                 enq_queue,
    input  byte_count_t               enq_bytes,
    input  logic                      deq_valid,
    input  queue_id_t                 deq_queue,
    input  byte_count_t               deq_bytes,
    input  logic                      occ_rd_valid,
    input  queue_id_t                 occ_rd_queue,
    output logic                      occ_rd_done,
    output byte_count_t               occ_rd_bytes,
    // Tail
    input  logic                      tail_wr_valid,
    input  queue_id_t                 tail_wr_queue,
    input  word_idx_t                 tail_wr_ptr,
    input  logic                      tail_wr_new_page,
    input  page_id_t                  tail_wr_page,
    input  logic                      tail_rd_valid,
    input  queue_id_t                 tail_rd_queue,
    output logic                      tail_rd_done,
    output word_idx_t                 tail_rd_ptr,
    output page_id_t                  tail_rd_page,
    output logic                      tail_rd_page_valid,
    // Head
    input  logic                      head_pop_valid,
    input  queue_id_t                 head_pop_queue,
    output logic                      head_pop_done,
    output word_idx_t                 head_pop_ptr,
    output page_id_t                  head_pop_page,
    output logic [`QS_NUM_QUEUES-1:0] queue_empty
);

    // Page RAM ports
    logic      ram_we;
    ram_addr_t ram_waddr;
    page_id_t  ram_wdata;
    ram_addr_t ram_raddr_a;
    ram_addr_t ram_raddr_b;
    page_id_t  ram_rdata_a;
    page_id_t  ram_rdata_b;

    queue_occupancy occupancy_i (.*);

    queue_page_list page_list_i (.*);

    page_ptr_ram page_ram_i (.*);

endmodule

// File: tb/queue_states_model.svh
/* Reference model of the queue-state store, included inside the testbench module.
   State arrays follow the pointer rules, functions return the expected replies. */
`ifndef QUEUE_STATES_MODEL_SVH
`define QUEUE_STATES_MODEL_SVH

byte_count_t               model_occ     [`QS_NUM_QUEUES];
word_idx_t                 model_tail    [`QS_NUM_QUEUES];
word_idx_t                 model_head    [`QS_NUM_QUEUES];
slot_idx_t                 model_wr_slot [`QS_NUM_QUEUES];
slot_idx_t                 model_rd_slot [`QS_NUM_QUEUES];
// Each queue's page list by slot
page_id_t                  model_pages   [`QS_NUM_QUEUES][`QS_NUM_PAGES];
logic [`QS_NUM_QUEUES-1:0] model_has_page;
logic [`QS_NUM_QUEUES-1:0] model_empty;

function automatic void reset_model();
    model_occ      = '{default: '0};
    model_tail     = '{default: '0};
    model_head     = '{default: '0};
    model_wr_slot  = '{default: '0};
    model_rd_slot  = '{default: '0};
    model_has_page = '0;
    model_empty    = '1;
endfunction

function automatic byte_count_t exp_occupancy(input queue_id_t q);
    return model_occ[q];
endfunction

function automatic logic [`QS_NUM_QUEUES-1:0] exp_empty();
    return model_empty;
endfunction

function automatic void exp_tail(input queue_id_t q, output word_idx_t ptr,
                                 output page_id_t page, output logic valid);
    ptr   = model_tail[q];
    page  = model_pages[q][model_wr_slot[q]];
    valid = model_has_page[q];
endfunction

// Reply taken before the advance, then the head moves on
function automatic void exp_pop(input queue_id_t q, output word_idx_t ptr,
                                output page_id_t page);
    ptr           = model_head[q];
    page          = model_pages[q][model_rd_slot[q]];
    model_head[q] = model_head[q] + 1'b1;
    if (model_head[q] == '0) model_rd_slot[q] = model_rd_slot[q] + 1'b1;
    if (model_head[q] == model_tail[q] && model_rd_slot[q] == model_wr_slot[q]) begin
        model_empty[q] = 1'b1;
    end
endfunction

function automatic void record_tail_write(input queue_id_t q, input word_idx_t ptr,
                                          input logic new_page, input page_id_t page);
    model_tail[q] = ptr;
    if (new_page) begin
        // First page of a list lands in slot 0
        if (model_has_page[q]) model_wr_slot[q] = model_wr_slot[q] + 1'b1;
        model_pages[q][model_wr_slot[q]] = page;
        model_has_page[q] = 1'b1;
    end
    model_empty[q] = 1'b0;
endfunction

`endif

// File: tb/queue_states_tb.sv
/* Self-checking testbench for the queue-state store, playing the page allocator.
   Every reply and the empty flags are compared with an included reference model. */
`timescale 1ns/1ps
`include "queue_states_cfg.svh"

module queue_states_tb
    import queue_states_pkg::*;
();

    logic        enqueue_queue_occupancy_a4l;
    logic        rst_n;
    // Request strobes and reply pulses
    logic        enq_valid, deq_valid, occ_rd_valid, occ_rd_done;
    logic        tail_wr_valid, tail_wr_new_page, tail_rd_valid, tail_rd_done, tail_rd_page_valid;
    logic        head_pop_valid, head_pop_done;
    queue_id_t   enq_queue, deq_queue, occ_rd_queue, tail_wr_queue, tail_rd_queue, head_pop_queue;
    byte_count_t enq_bytes, deq_bytes, occ_rd_bytes;
    word_idx_t   tail_wr_ptr, tail_rd_ptr, head_pop_ptr;
    page_id_t    tail_wr_page, tail_rd_page, head_pop_page;
    logic [`QS_NUM_QUEUES-1:0] queue_empty;

    integer    seed = 65855;
    int        errors = 0;
    int        checks = 0;
    int        waits;
    // Words written and not yet popped
    int        avail [`QS_NUM_QUEUES];
    logic      append_prev;
    queue_id_t append_q;

    // Requests sampled at the last edge that owe a done pulse now
    logic      occ_rd_owed  = 1'b0;
    logic      tail_rd_owed = 1'b0;
    logic      pop_owed     = 1'b0;

    // Expected replies in request order
    byte_count_t occ_exp        [$];
    word_idx_t   tail_ptr_exp   [$];
    page_id_t    tail_page_exp  [$];
    logic        tail_valid_exp [$];
    word_idx_t   pop_ptr_exp    [$];
    page_id_t    pop_page_exp   [$];

    `include "queue_states_model.svh"

    queue_states dut_i (.*);

    initial begin
        enqueue_queue_occupancy_a4l = 1'b0;
        forever #50 enqueue_queue_occupancy_a4l = ~enqueue_queue_occupancy_a4l;
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic flag_extra_reply(input string what);
        errors++;
        $display("Unexpected %s reply at %0t with no request outstanding", what, $time);
    endtask

    // Replies are stable mid-cycle
    always @(negedge enqueue_queue_occupancy_a4l) begin
        // Each done pulse lands exactly one cycle after its request
        if (rst_n) begin
            check_value("occ_rd_done", occ_rd_owed, occ_rd_done);
            check_value("tail_rd_done", tail_rd_owed, tail_rd_done);
            check_value("head_pop_done", pop_owed, head_pop_done);
        end
        if (occ_rd_done) begin
            if (occ_exp.size() == 0) flag_extra_reply("occupancy read");
            else check_value("occ_rd_bytes", occ_exp.pop_front(), occ_rd_bytes);
        end
        if (tail_rd_done) begin
            if (tail_ptr_exp.size() == 0) begin
                flag_extra_reply("tail read");
            end else begin
                check_value("tail_rd_ptr", tail_ptr_exp.pop_front(), tail_rd_ptr);
                check_value("tail_rd_page_valid", tail_valid_exp[0], tail_rd_page_valid);
                // No page to compare before the list holds one
                if (tail_valid_exp[0]) check_value("tail_rd_page", tail_page_exp[0], tail_rd_page);
                tail_valid_exp.delete(0);
                tail_page_exp.delete(0);
            end
        end
        if (head_pop_done) begin
            if (pop_ptr_exp.size() == 0) begin
                flag_extra_reply("head pop");
            end else begin
                check_value("head_pop_ptr", pop_ptr_exp.pop_front(), head_pop_ptr);
                check_value("head_pop_page", pop_page_exp.pop_front(), head_pop_page);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic clear_requests();
        {enq_valid, deq_valid, occ_rd_valid, tail_wr_valid, tail_rd_valid, head_pop_valid} = '0;
        {enq_queue, deq_queue, occ_rd_queue, tail_wr_queue, tail_rd_queue, head_pop_queue} = '0;
        {enq_bytes, deq_bytes, tail_wr_ptr, tail_wr_new_page, tail_wr_page} = '0;
    endtask

    // Next word of the queue opens a page at offset 0
    task automatic write_word(input queue_id_t q);
        tail_wr_valid    = 1'b1;
        tail_wr_queue    = q;
        tail_wr_ptr      = model_tail[q] + 1'b1;
        tail_wr_new_page = (model_tail[q] == '0);
        tail_wr_page     = $random(seed);
    endtask

    task automatic drive_random(input logic occ_ops, input logic page_ops);
        queue_id_t q;
        if (occ_ops) begin
            enq_queue    = $random(seed);
            enq_bytes    = `QS_BYTES_PER_WORD * ({$random(seed)} % 9);
            enq_valid    = ({$random(seed)} % 2 == 1) && (model_occ[enq_queue] < 400);
            deq_queue    = $random(seed);
            deq_bytes    = {$random(seed)} % (model_occ[deq_queue] + 1);
            deq_valid    = {$random(seed)} % 2;
            occ_rd_queue = $random(seed);
            occ_rd_valid = {$random(seed)} % 2;
        end
        if (page_ops) begin
            q = $random(seed);
            if ({$random(seed)} % 2 == 1 && avail[q] < 16) write_word(q);
            // Page RAM lags an append by a cycle
            q = $random(seed);
            if (!(append_prev && append_q == q) && {$random(seed)} % 2 == 1) begin
                tail_rd_valid = 1'b1;
                tail_rd_queue = q;
            end
            q = $random(seed);
            if (!(append_prev && append_q == q) && avail[q] > 0 && {$random(seed)} % 4 != 0) begin
                head_pop_valid = 1'b1;
                head_pop_queue = q;
            end
        end
    endtask

    // Edge where the DUT samples followed by model update and empty check
    task automatic advance_cycle();
        word_idx_t ptr;
        page_id_t  page;
        logic      valid;
        @(posedge enqueue_queue_occupancy_a4l);
        occ_rd_owed  = occ_rd_valid;
        tail_rd_owed = tail_rd_valid;
        pop_owed     = head_pop_valid;
        if (occ_rd_valid) occ_exp.push_back(exp_occupancy(occ_rd_queue));
        if (tail_rd_valid) begin
            exp_tail(tail_rd_queue, ptr, page, valid);
            tail_ptr_exp.push_back(ptr);
            tail_page_exp.push_back(page);
            tail_valid_exp.push_back(valid);
        end
        if (head_pop_valid) begin
            exp_pop(head_pop_queue, ptr, page);
            pop_ptr_exp.push_back(ptr);
            pop_page_exp.push_back(page);
            avail[head_pop_queue]--;
        end
        // Same-queue pair nets out to old + enq - deq
        if (enq_valid) model_occ[enq_queue] = model_occ[enq_queue] + enq_bytes;
        if (deq_valid) model_occ[deq_queue] = model_occ[deq_queue] - deq_bytes;
        if (tail_wr_valid) begin
            record_tail_write(tail_wr_queue, tail_wr_ptr, tail_wr_new_page, tail_wr_page);
            avail[tail_wr_queue]++;
        end
        append_prev = tail_wr_valid && tail_wr_new_page;
        append_q    = tail_wr_queue;
        #1;
        check_value("queue_empty", exp_empty(), queue_empty);
        clear_requests();
    endtask

    initial begin
        int q;
        reset_model();
        clear_requests();
        avail       = '{default: 0};
        append_prev = 1'b0;
        append_q    = '0;
        rst_n       = 1'b0;
        repeat (2) @(posedge enqueue_queue_occupancy_a4l);
        #1;
        rst_n = 1'b1;

        // Zero counts and no pages after reset
        for (q = 0; q < `QS_NUM_QUEUES; q++) begin
            occ_rd_valid  = 1'b1;
            occ_rd_queue  = q;
            tail_rd_valid = 1'b1;
            tail_rd_queue = q;
            advance_cycle();
        end

        repeat (60) begin
            drive_random(1'b1, 1'b0);
            advance_cycle();
        end

        // Three pages per queue with each write read back after an idle cycle
        for (q = 0; q < `QS_NUM_QUEUES; q++) begin
            repeat (9) begin
                write_word(q);
                advance_cycle();
                advance_cycle();
                tail_rd_valid = 1'b1;
                tail_rd_queue = q;
                advance_cycle();
            end
        end

        for (q = 0; q < `QS_NUM_QUEUES; q++) begin
            while (avail[q] > 0) begin
                head_pop_valid = 1'b1;
                head_pop_queue = q;
                advance_cycle();
            end
        end

        // Back-to-back mix on every group
        repeat (300) begin
            drive_random(1'b1, 1'b1);
            advance_cycle();
        end

        waits = 0;
        while (occ_exp.size() + tail_ptr_exp.size() + pop_ptr_exp.size() != 0 && waits < 20) begin
            advance_cycle();
            waits++;
        end
        if (occ_exp.size() != 0) begin
            errors++;
            $display("Timeout: occupancy read reply missing after 20 cycles");
        end
        if (tail_ptr_exp.size() != 0) begin
            errors++;
            $display("Timeout: tail read reply missing after 20 cycles");
        end
        if (pop_ptr_exp.size() != 0) begin
            errors++;
            $display("Timeout: head pop reply missing after 20 cycles");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+source
+incdir+tb
source/queue_states_pkg.sv
source/queue_occupancy.sv
source/page_ptr_ram.sv
source/queue_page_list.sv
source/queue_states.sv
tb/queue_states_tb.sv
